// File: src/wtable_cfg.svh
// Write-ordering table configuration macros: entry count and address width
`ifndef WTABLE_CFG_SVH
`define WTABLE_CFG_SVH

// Number of table entries, must be a power of two
`define WTABLE_ENTRIES 4

// Physical address width of the AR and AW buses
`define WTABLE_PADDR 40

`endif

// File: src/wtable_pkg.sv
// Write-ordering table types: bus address, recorded tag, entry index, occupancy count
`include "wtable_cfg.svh"

package wtable_pkg;

  // Full bus address
  typedef logic [`WTABLE_PADDR-1:0] paddr_t;

  // Recorded address, bits 13 to 4 of the write address
  typedef logic [9:0] wtable_tag_t;

  // Entry index, log2 of the entry count
  localparam int unsigned WTABLE_IDX_W = $clog2(`WTABLE_ENTRIES);
  typedef logic [WTABLE_IDX_W-1:0] wtable_idx_t;

  // Occupancy count, one extra bit to hold the full value
  typedef logic [WTABLE_IDX_W:0] wtable_cnt_t;

endpackage

// File: src/wtable_entry_if.sv
// Interface between the allocator and one table entry: create and pop controls, valid
`timescale 1ns/1ps

interface wtable_entry_if;
  import wtable_pkg::*;

  // One-cycle strobes, never both high together
  logic        create_en;
  logic        pop_en;

  // Record loaded on create
  wtable_tag_t create_tag;
  logic        create_so;
  logic        create_burst;

  // Entry holds a live record
  logic        vld;

  modport alloc (
    output create_en, pop_en, create_tag, create_so, create_burst,
    input  vld
  );

  modport entry (
    input  create_en, pop_en, create_tag, create_so, create_burst,
    output vld
  );

endinterface

// File: src/wtable_hit_if.sv
// Interface from one table entry to the hazard combiner: AR and AW hit flags
`timescale 1ns/1ps

interface wtable_hit_if;

  // Same-line hit for a read
  logic ar_hit_addr;
  // Non-modifiable read behind a strongly-ordered write
  logic ar_hit_so;
  // Overlap hit for a write, 16 or 64 byte granularity
  logic aw_hit_addr;
  // Non-modifiable write behind a strongly-ordered write
  logic aw_hit_so;

  modport entry (
    output ar_hit_addr, ar_hit_so, aw_hit_addr, aw_hit_so
  );

  modport hazard (
    input  ar_hit_addr, ar_hit_so, aw_hit_addr, aw_hit_so
  );

endinterface

// File: src/wtable_alloc.sv
// In-order circular allocator: write/read pointers, occupancy count, per-entry strobes
`timescale 1ns/1ps
`include "wtable_cfg.svh"

module wtable_alloc (
  input  logic                  wtable_clk,
  input  logic                  cpurst_b,
  input  logic                  wt_create,
  input  logic                  wt_pop,
  input  wtable_pkg::paddr_t    awaddr,
  input  logic [3:0]            awcache,
  input  logic [1:0]            awlen,
  wtable_entry_if.alloc         ents [`WTABLE_ENTRIES-1:0],
  output wtable_pkg::wtable_cnt_t wtable_cnt,
  output logic                  wtable_full
);
  import wtable_pkg::*;

  wtable_idx_t               wr_ptr;
  wtable_idx_t               rd_ptr;
  wtable_cnt_t               cnt;
  logic [`WTABLE_ENTRIES-1:0] vld_vec;
  logic                      head_vld;
  logic                      create_ok;
  logic                      pop_ok;
  logic                      full;

  // Gather entry valids, interface arrays need constant indices
  for (genvar i = 0; i < `WTABLE_ENTRIES; i++) begin : g_vld
    assign vld_vec[i] = ents[i].vld;
  end

  // Oldest record present, i.e. table not empty
  assign head_vld = vld_vec[rd_ptr];

  assign full = (cnt == wtable_cnt_t'(`WTABLE_ENTRIES));

  // Create dropped when full, even with a pop in the same cycle
  assign create_ok = wt_create & ~full;
  // Pop on empty table ignored
  assign pop_ok    = wt_pop & head_vld;

  // Pointers wrap for free, entry count is a power of two
  always_ff @(posedge wtable_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      wr_ptr <= '0;
    end else if (create_ok) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge wtable_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      rd_ptr <= '0;
    end else if (pop_ok) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Occupancy, create and pop together leave it unchanged
  always_ff @(posedge wtable_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      cnt <= '0;
    end else if (create_ok != pop_ok) begin
      cnt <= create_ok ? cnt + 1'b1 : cnt - 1'b1;
    end
  end

  // Per-entry strobes and broadcast record
  for (genvar i = 0; i < `WTABLE_ENTRIES; i++) begin : g_ctl
    // Create and pop never meet on one entry: equal pointers with
    // room left means empty, so pop_ok is low there
    assign ents[i].create_en    = create_ok & (wr_ptr == wtable_idx_t'(i));
    assign ents[i].pop_en       = pop_ok & (rd_ptr == wtable_idx_t'(i));
    // Tag is the 16-byte granule within a 16 KB window
    assign ents[i].create_tag   = awaddr[13:4];
    // Non-modifiable write, strongly ordered
    assign ents[i].create_so    = ~awcache[1];
    // Four-beat burst covers the whole 64-byte line
    assign ents[i].create_burst = (awlen == 2'b11);
  end

  assign wtable_cnt  = cnt;
  assign wtable_full = full;

endmodule

// File: src/wtable_entry.sv
// One write-ordering table entry: recorded tag, SO and burst flags, AR/AW hit logic
`timescale 1ns/1ps

module wtable_entry (
  input  logic               wtable_clk,
  input  logic               cpurst_b,
  wtable_entry_if.entry      ctl,
  wtable_hit_if.entry        hit,
  input  wtable_pkg::paddr_t araddr,
  input  logic [3:0]         arcache,
  input  wtable_pkg::paddr_t awaddr,
  input  logic [3:0]         awcache,
  input  logic [1:0]         awlen
);
  import wtable_pkg::*;

  logic        vld;
  wtable_tag_t tag;
  logic        so;
  logic        burst;
  logic        burst_sel;

  // Create wins, the allocator never pairs it with pop here
  always_ff @(posedge wtable_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      vld <= 1'b0;
    end else if (ctl.create_en) begin
      vld <= 1'b1;
    end else if (ctl.pop_en) begin
      vld <= 1'b0;
    end
  end

  // Record fields, meaningful only while vld
  always_ff @(posedge wtable_clk) begin
    if (ctl.create_en) begin
      tag   <= ctl.create_tag;
      so    <= ctl.create_so;
      burst <= ctl.create_burst;
    end
  end

  assign ctl.vld = vld;

  // Either side a burst, compare at line granularity
  assign burst_sel = burst | (awlen == 2'b11);

  // Read hits anywhere in the recorded 64-byte line
  assign hit.ar_hit_addr = vld & (araddr[13:6] == tag[9:2]);

  // Write overlap, 64 bytes for bursts, else 16 bytes
  assign hit.aw_hit_addr = vld & (burst_sel ? (awaddr[13:6] == tag[9:2])
                                            : (awaddr[13:4] == tag));

  // Non-modifiable access behind a strongly-ordered write
  assign hit.ar_hit_so = vld & so & ~arcache[1];
  assign hit.aw_hit_so = vld & so & ~awcache[1];

endmodule

// File: src/wtable_hazard.sv
// Hazard combiner: ORs per-entry hits into AR and AW stalls, adds full stall on AW
`timescale 1ns/1ps
`include "wtable_cfg.svh"

module wtable_hazard (
  wtable_hit_if.hazard hits [`WTABLE_ENTRIES-1:0],
  input  logic         wtable_full,
  output logic         ar_stall,
  output logic         aw_stall
);

  logic [`WTABLE_ENTRIES-1:0] ar_addr_vec;
  logic [`WTABLE_ENTRIES-1:0] ar_so_vec;
  logic [`WTABLE_ENTRIES-1:0] aw_addr_vec;
  logic [`WTABLE_ENTRIES-1:0] aw_so_vec;
  logic                       ar_any_hit;
  logic                       aw_any_hit;

  // Flatten the interface array into hit vectors
  for (genvar i = 0; i < `WTABLE_ENTRIES; i++) begin : g_hit
    assign ar_addr_vec[i] = hits[i].ar_hit_addr;
    assign ar_so_vec[i]   = hits[i].ar_hit_so;
    assign aw_addr_vec[i] = hits[i].aw_hit_addr;
    assign aw_so_vec[i]   = hits[i].aw_hit_so;
  end

  // Address or ordering hazard on any entry
  assign ar_any_hit = (|ar_addr_vec) | (|ar_so_vec);
  assign aw_any_hit = (|aw_addr_vec) | (|aw_so_vec);

  assign ar_stall = ar_any_hit;
  // No room to record another write
  assign aw_stall = aw_any_hit | wtable_full;

endmodule

// File: src/wtable_top.sv
// Write-ordering table top: allocator, entry array and hazard combiner
`timescale 1ns/1ps
`include "wtable_cfg.svh"

module wtable_top (
  input  logic                    wtable_clk,
  input  logic                    cpurst_b,
  input  logic                    wt_create,
  input  logic                    wt_pop,
  input  wtable_pkg::paddr_t      araddr,
  input  logic [3:0]              arcache,
  input  wtable_pkg::paddr_t      awaddr,
  input  logic [3:0]              awcache,
  input  logic [1:0]              awlen,
  output logic                    ar_stall,
  output logic                    aw_stall,
  output logic                    wtable_full,
  output wtable_pkg::wtable_cnt_t wtable_cnt
);

  // Allocator to entry controls, one per entry
  wtable_entry_if ent_if [`WTABLE_ENTRIES-1:0] ();
  // Entry to combiner hit flags, one per entry
  wtable_hit_if   hit_if [`WTABLE_ENTRIES-1:0] ();

  wtable_alloc x_wtable_alloc (
    .wtable_clk  (wtable_clk ),
    .cpurst_b    (cpurst_b   ),
    .wt_create   (wt_create  ),
    .wt_pop      (wt_pop     ),
    .awaddr      (awaddr     ),
    .awcache     (awcache    ),
    .awlen       (awlen      ),
    .ents        (ent_if     ),
    .wtable_cnt  (wtable_cnt ),
    .wtable_full (wtable_full)
  );

  // Identical entries, all see the same AR and AW buses
  for (genvar i = 0; i < `WTABLE_ENTRIES; i++) begin : g_entry
    wtable_entry x_wtable_entry (
      .wtable_clk (wtable_clk),
      .cpurst_b   (cpurst_b  ),
      .ctl        (ent_if[i] ),
      .hit        (hit_if[i] ),
      .araddr     (araddr    ),
      .arcache    (arcache   ),
      .awaddr     (awaddr    ),
      .awcache    (awcache   ),
      .awlen      (awlen     )
    );
  end

  wtable_hazard x_wtable_hazard (
    .hits        (hit_if     ),
    .wtable_full (wtable_full),
    .ar_stall    (ar_stall   ),
    .aw_stall    (aw_stall   )
  );

endmodule

// File: test/wtable_check.sv
// Write-ordering table checker: reference queue model and per-cycle output comparison
`timescale 1ns/1ps
`include "wtable_cfg.svh"

module wtable_check (
  input  logic                    wtable_clk,
  input  logic                    cpurst_b,
  input  logic                    wt_create,
  input  logic                    wt_pop,
  input  wtable_pkg::paddr_t      araddr,
  input  logic [3:0]              arcache,
  input  wtable_pkg::paddr_t      awaddr,
  input  logic [3:0]              awcache,
  input  logic [1:0]              awlen,
  input  logic                    ar_stall,
  input  logic                    aw_stall,
  input  logic                    wtable_full,
  input  wtable_pkg::wtable_cnt_t wtable_cnt,
  output int                      err_cnt
);
  import wtable_pkg::*;

  // One outstanding write as the model sees it
  typedef struct packed {
    logic        burst;
    logic        so;
    wtable_tag_t tag;
  } rec_t;

  // Oldest write at the front
  rec_t q [$];

  initial begin
    err_cnt = 0;
  end

  // Read inside the write's 64-byte line, or non-modifiable behind SO write
  function automatic logic read_blocked(input rec_t r);
    logic same_line;
    same_line = (araddr[13:6] == r.tag[9:2]);
    return same_line | (r.so & ~arcache[1]);
  endfunction

  // Write overlap at line size for any burst and 16 bytes otherwise
  function automatic logic write_blocked(input rec_t r);
    logic line_gran;
    logic overlap;
    line_gran = r.burst | (awlen == 2'd3);
    if (line_gran) begin
      overlap = (awaddr[13:6] == r.tag[9:2]);
    end else begin
      overlap = (awaddr[13:4] == r.tag);
    end
    return overlap | (r.so & ~awcache[1]);
  endfunction

  // Report one mismatch with time and signal name
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt = err_cnt + 1;
      $display("Error at %0t: %s is %0h, model expects %0h", $time, name, got, exp);
    end
  endtask

  // Queue update on the same edges as the DUT state
  always @(posedge wtable_clk or negedge cpurst_b) begin : model_update
    rec_t nrec;
    logic was_full;
    logic was_empty;
    if (!cpurst_b) begin
      q.delete();
    end else begin
      // Occupancy before this edge decides both strobes
      was_full  = (q.size() == `WTABLE_ENTRIES);
      was_empty = (q.size() == 0);
      if (wt_pop && !was_empty) begin
        q.delete(0);
      end
      // Create while full is lost even with a pop
      if (wt_create && !was_full) begin
        nrec.tag   = awaddr[13:4];
        nrec.so    = ~awcache[1];
        nrec.burst = (awlen == 2'd3);
        q.push_back(nrec);
      end
    end
  end

  // Inputs and state both settled at the falling edge
  always @(negedge wtable_clk) begin : compare_outputs
    logic        exp_ar;
    logic        exp_aw;
    logic        exp_full;
    wtable_cnt_t exp_cnt;
    if (cpurst_b) begin
      exp_ar = 1'b0;
      exp_aw = 1'b0;
      foreach (q[i]) begin
        exp_ar = exp_ar | read_blocked(q[i]);
        exp_aw = exp_aw | write_blocked(q[i]);
      end
      exp_full = (q.size() == `WTABLE_ENTRIES);
      // No room for another write
      exp_aw  = exp_aw | exp_full;
      exp_cnt = wtable_cnt_t'(q.size());
      compare_value("ar_stall", 32'(ar_stall), 32'(exp_ar));
      compare_value("aw_stall", 32'(aw_stall), 32'(exp_aw));
      compare_value("wtable_full", 32'(wtable_full), 32'(exp_full));
      compare_value("wtable_cnt", 32'(wtable_cnt), 32'(exp_cnt));
    end
  end

endmodule

// File: test/wtable_tb.sv
// Write-ordering table testbench: clock, reset, LFSR stimulus, test sequence, timeout
`timescale 1ns/1ps
`include "wtable_cfg.svh"

module wtable_tb;
  import wtable_pkg::*;

  // Cycles per test, their sum sets the timeout
  localparam int RESET_CYC = 5;
  localparam int IDLE_CYC  = 20;
  localparam int FILL_CYC  = 2 * `WTABLE_ENTRIES;
  localparam int ADDR_CYC  = `WTABLE_ENTRIES + 3 + 40;
  localparam int ORDER_CYC = `WTABLE_ENTRIES + 3 + 40;
  localparam int DRAIN_CYC = 2 + 8 + 6;
  localparam int MIX_CYC   = 400;
  // Two wrap-up cycles per test plus slack
  localparam int LIMIT_CYC = RESET_CYC + IDLE_CYC + FILL_CYC + ADDR_CYC + ORDER_CYC
                             + DRAIN_CYC + MIX_CYC + 6 * 2 + 50;

  logic        wtable_clk;
  logic        cpurst_b;
  logic        wt_create;
  logic        wt_pop;
  paddr_t      araddr;
  logic [3:0]  arcache;
  paddr_t      awaddr;
  logic [3:0]  awcache;
  logic [1:0]  awlen;
  logic        ar_stall;
  logic        aw_stall;
  logic        wtable_full;
  wtable_cnt_t wtable_cnt;
  int          err_cnt;
  logic [31:0] lfsr;
  int          cycles = 0;
  int          tests_run;
  int          tests_failed;
  int          err_mark;

  wtable_top i_dut (
    .wtable_clk  (wtable_clk ),
    .cpurst_b    (cpurst_b   ),
    .wt_create   (wt_create  ),
    .wt_pop      (wt_pop     ),
    .araddr      (araddr     ),
    .arcache     (arcache    ),
    .awaddr      (awaddr     ),
    .awcache     (awcache    ),
    .awlen       (awlen      ),
    .ar_stall    (ar_stall   ),
    .aw_stall    (aw_stall   ),
    .wtable_full (wtable_full),
    .wtable_cnt  (wtable_cnt )
  );

  wtable_check i_check (
    .wtable_clk  (wtable_clk ),
    .cpurst_b    (cpurst_b   ),
    .wt_create   (wt_create  ),
    .wt_pop      (wt_pop     ),
    .araddr      (araddr     ),
    .arcache     (arcache    ),
    .awaddr      (awaddr     ),
    .awcache     (awcache    ),
    .awlen       (awlen      ),
    .ar_stall    (ar_stall   ),
    .aw_stall    (aw_stall   ),
    .wtable_full (wtable_full),
    .wtable_cnt  (wtable_cnt ),
    .err_cnt     (err_cnt    )
  );

  // 8 ns period
  always #4 wtable_clk = ~wtable_clk;

  // Run limit
  always @(posedge wtable_clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT_CYC) begin
      $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYC);
      $display("Some tests failed");
      $finish;
    end
  end

  // Fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic        fb;
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // Small tag pool, first two share a 64-byte line
  function automatic logic [9:0] pool_tag(input logic [1:0] sel);
    case (sel)
      2'd0:    pool_tag = 10'h120;
      2'd1:    pool_tag = 10'h121;
      2'd2:    pool_tag = 10'h127;
      default: pool_tag = 10'h2a5;
    endcase
  endfunction

  // Pool tag in bits 13 to 4, random elsewhere
  function automatic paddr_t rand_addr();
    logic [31:0] hi;
    logic [31:0] sel;
    logic [31:0] lo;
    hi  = rand_bits(`WTABLE_PADDR - 14);
    sel = rand_bits(2);
    lo  = rand_bits(4);
    return {hi[`WTABLE_PADDR-15:0], pool_tag(sel[1:0]), lo[3:0]};
  endfunction

  // One stimulus cycle, mod_only keeps both accesses modifiable
  task automatic drive_cycle(input logic create, input logic pop, input logic mod_only);
    logic [31:0] c;
    logic [31:0] l;
    @(posedge wtable_clk);
    #1;
    wt_create = create;
    wt_pop    = pop;
    araddr    = rand_addr();
    awaddr    = rand_addr();
    c         = rand_bits(8);
    l         = rand_bits(2);
    arcache   = c[3:0];
    awcache   = c[7:4];
    awlen     = l[1:0];
    if (mod_only) begin
      arcache[1] = 1'b1;
      awcache[1] = 1'b1;
    end
  endtask

  // Quiet cycle so the last strobe gets checked, then one result line
  task automatic end_test(input string name);
    int errs;
    drive_cycle(1'b0, 1'b0, 1'b1);
    @(negedge wtable_clk);
    #1;
    errs      = err_cnt - err_mark;
    err_mark  = err_cnt;
    tests_run = tests_run + 1;
    if (errs != 0) begin
      tests_failed = tests_failed + 1;
    end
    $display("test %0d %s: %s, %0d mismatches", tests_run, name,
             (errs == 0) ? "ok" : "FAILED", errs);
  endtask

  task automatic idle_after_reset();
    repeat (IDLE_CYC) drive_cycle(1'b0, 1'b0, 1'b0);
    end_test("idle after reset");
  endtask

  // Second half of the creates arrive while full
  task automatic fill_table();
    repeat (FILL_CYC) drive_cycle(1'b1, 1'b0, 1'b0);
    end_test("fill until full");
  endtask

  // Modifiable only, so every stall is an address hit
  task automatic addr_hazards();
    repeat (`WTABLE_ENTRIES) drive_cycle(1'b0, 1'b1, 1'b1);
    repeat (3) drive_cycle(1'b1, 1'b0, 1'b1);
    repeat (40) drive_cycle(1'b0, 1'b0, 1'b1);
    end_test("address hazards");
  endtask

  // Random cache bits record SO writes and non-modifiable accesses
  task automatic order_hazards();
    repeat (`WTABLE_ENTRIES) drive_cycle(1'b0, 1'b1, 1'b1);
    repeat (3) drive_cycle(1'b1, 1'b0, 1'b0);
    repeat (40) drive_cycle(1'b0, 1'b0, 1'b0);
    end_test("ordering hazards");
  endtask

  // Fill, create with pop, then pops past empty
  task automatic drain_in_order();
    repeat (2) drive_cycle(1'b1, 1'b0, 1'b0);
    repeat (8) drive_cycle(1'b1, 1'b1, 1'b0);
    repeat (6) drive_cycle(1'b0, 1'b1, 1'b0);
    end_test("in-order pops");
  endtask

  task automatic random_mix();
    logic [31:0] s;
    repeat (MIX_CYC) begin
      s = rand_bits(2);
      drive_cycle(s[0], s[1], 1'b0);
    end
    end_test("random mix");
  endtask

  initial begin
    lfsr         = 32'h22d7_9621;
    wtable_clk   = 1'b0;
    cpurst_b     = 1'b0;
    wt_create    = 1'b0;
    wt_pop       = 1'b0;
    araddr       = '0;
    arcache      = '0;
    awaddr       = '0;
    awcache      = '0;
    awlen        = '0;
    tests_run    = 0;
    tests_failed = 0;
    err_mark     = 0;
    repeat (RESET_CYC) @(posedge wtable_clk);
    #1;
    cpurst_b = 1'b1;
    idle_after_reset();
    fill_table();
    addr_hazards();
    order_hazards();
    drain_in_order();
    random_mix();
    $display("tests run %0d, tests failed %0d, mismatches %0d",
             tests_run, tests_failed, err_cnt);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+src
src/wtable_pkg.sv
src/wtable_entry_if.sv
src/wtable_hit_if.sv
src/wtable_alloc.sv
src/wtable_entry.sv
src/wtable_hazard.sv
src/wtable_top.sv
test/wtable_check.sv
test/wtable_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the write-ordering table testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f sources.f --top-module wtable_tb -o wtable_sim
./obj_dir/wtable_sim | tee "$LOG"

if grep -q "Some tests failed" "$LOG"; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
